// File: Makefile
# Verilator build for the memory-access datapath

VERILATOR ?= verilator
TOP       ?= mem_path_tb
FILELIST  ?= mem_path.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing -j 0

SIM      := $(OBJ_DIR)/V$(TOP)
SRCS     := $(shell grep -v '^+' $(FILELIST))
PASS_MSG := *** TEST PASSED ***

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): $(FILELIST) $(SRCS)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

# The run fails unless the simulation output holds the pass message
run: $(SIM)
	@out="$$($(SIM))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF '$(PASS_MSG)'

clean:
	rm -rf $(OBJ_DIR)

// File: common/mem_path_pkg.sv
package mem_path_pkg;

    // RV32I widths
    localparam int unsigned XLEN       = 32;
    localparam int unsigned REG_ADDR_W = 5;
    localparam int unsigned MBE_W      = XLEN / 8;

    // Only the memory opcodes of the base ISA are handled here
    typedef enum logic [6:0] {
        op_load  = 7'b0000011,
        op_store = 7'b0100011
    } rv32i_opcode_t;

    typedef enum logic [2:0] {
        lb  = 3'b000,
        lh  = 3'b001,
        lw  = 3'b010,
        lbu = 3'b100,
        lhu = 3'b101
    } load_funct3_t;

    typedef enum logic [2:0] {
        sb = 3'b000,
        sh = 3'b001,
        sw = 3'b010
    } store_funct3_t;

    // One request as it arrives from the issue side
    // The offset is already sign-extended and the store data sits in its low bits
    typedef struct packed {
        rv32i_opcode_t         opcode;
        logic [2:0]            funct3;
        logic [XLEN-1:0]       base;
        logic [XLEN-1:0]       offset;
        logic [XLEN-1:0]       store_data;
        logic [REG_ADDR_W-1:0] rd;
    } mem_req_t;

    // One access after address generation
    // addr keeps the low two bits so the writeback stage can pick the lane
    typedef struct packed {
        rv32i_opcode_t         opcode;
        logic [2:0]            funct3;
        logic [XLEN-1:0]       addr;
        logic [XLEN-1:0]       wdata;
        logic [MBE_W-1:0]      mbe;
        logic [REG_ADDR_W-1:0] rd;
    } mem_access_t;

endpackage

// File: mem_path.f
common/mem_path_pkg.sv
verilog/mem_addr_stage.sv
verilog/mem_request_buffer.sv
verilog/load_writeback.sv
verilog/mem_path_top.sv
test/data_memory_model.sv
test/mem_path_tb.sv

// File: test/data_memory_model.sv
`timescale 1ns/1ps

module data_memory_model (
    input  logic                           clk,
    input  logic                           rst,
    input  logic                           data_read,
    input  logic                           data_write,
    input  logic [mem_path_pkg::MBE_W-1:0] data_mbe,
    input  logic [mem_path_pkg::XLEN-1:0]  data_addr,
    input  logic [mem_path_pkg::XLEN-1:0]  data_wdata,
    output logic                           data_resp,
    output logic [mem_path_pkg::XLEN-1:0]  data_rdata
);

    logic [31:0] mem [0:63];
    logic [1:0]  wait_cnt;
    logic [5:0]  index;
    logic [31:0] lane_mask;
    integer      seed;

    // Every byte holds its own byte address XOR 0xC3
    function automatic logic [31:0] fill_word(input logic [5:0] w);
        logic [7:0] base_byte;
        base_byte = {w, 2'b00};
        return {base_byte ^ 8'hC0, base_byte ^ 8'hC1, base_byte ^ 8'hC2, base_byte ^ 8'hC3};
    endfunction

    assign index     = data_addr[7:2];
    assign lane_mask = {{8{data_mbe[3]}}, {8{data_mbe[2]}}, {8{data_mbe[1]}}, {8{data_mbe[0]}}};

    initial begin
        seed       = 32'h7a3e;
        data_resp  = 1'b0;
        data_rdata = '0;
    end

    // The wait for the next access is drawn ahead so that a zero count answers after one cycle
    always @(posedge clk) begin
        if (rst) begin
            data_resp  <= 1'b0;
            data_rdata <= '0;
            wait_cnt   <= 2'($unsigned($random(seed)) % 3);
            for (int w = 0; w < 64; w++) begin
                mem[w[5:0]] <= fill_word(w[5:0]);
            end
        end else if (data_resp) begin
            // The access completes at this edge, so the write lands now
            if (data_write) begin
                mem[index] <= (mem[index] & ~lane_mask) | (data_wdata & lane_mask);
            end
            data_resp <= 1'b0;
            wait_cnt  <= 2'($unsigned($random(seed)) % 3);
        end else if (data_read || data_write) begin
            if (wait_cnt == 2'd0) begin
                data_resp  <= 1'b1;
                data_rdata <= data_read ? mem[index] : '0;
            end else begin
                wait_cnt <= wait_cnt - 2'd1;
            end
        end
    end

endmodule

// File: test/mem_path_tb.sv
`timescale 1ns/1ps

module mem_path_tb;

    localparam int HALF_PERIOD = 10;

    // One row of the stimulus table with its expected results
    typedef struct packed {
        mem_path_pkg::rv32i_opcode_t         opcode;
        logic [2:0]                          funct3;
        logic [mem_path_pkg::XLEN-1:0]       base;
        logic [mem_path_pkg::XLEN-1:0]       offset;
        logic [mem_path_pkg::XLEN-1:0]       store_data;
        logic [mem_path_pkg::REG_ADDR_W-1:0] rd;
        logic [mem_path_pkg::MBE_W-1:0]      exp_mbe;
        logic [mem_path_pkg::XLEN-1:0]       exp_data;
    } vec_t;

    logic                                clk;
    logic                                rst;
    logic                                op_valid;
    mem_path_pkg::mem_req_t              op_req;
    logic                                stall;
    logic                                data_read;
    logic                                data_write;
    logic [mem_path_pkg::MBE_W-1:0]      data_mbe;
    logic [mem_path_pkg::XLEN-1:0]       data_addr;
    logic [mem_path_pkg::XLEN-1:0]       data_wdata;
    logic                                data_resp;
    logic [mem_path_pkg::XLEN-1:0]       data_rdata;
    logic                                wb_valid;
    logic [mem_path_pkg::REG_ADDR_W-1:0] wb_rd;
    logic [mem_path_pkg::XLEN-1:0]       wb_data;

    vec_t  vecs[$];
    string vec_names[$];
    int    port_q[$];
    int    wb_q[$];
    int    port_idx;
    int    wb_idx;
    int    errors;
    int    checks;
    int    stall_cycles;
    bit    table_ready;

    mem_path_top i_mem_path_top (
        .clk        (clk),
        .rst        (rst),
        .op_valid   (op_valid),
        .op_req     (op_req),
        .stall      (stall),
        .data_read  (data_read),
        .data_write (data_write),
        .data_mbe   (data_mbe),
        .data_addr  (data_addr),
        .data_wdata (data_wdata),
        .data_resp  (data_resp),
        .data_rdata (data_rdata),
        .wb_valid   (wb_valid),
        .wb_rd      (wb_rd),
        .wb_data    (wb_data)
    );

    data_memory_model i_data_memory_model (
        .clk        (clk),
        .rst        (rst),
        .data_read  (data_read),
        .data_write (data_write),
        .data_mbe   (data_mbe),
        .data_addr  (data_addr),
        .data_wdata (data_wdata),
        .data_resp  (data_resp),
        .data_rdata (data_rdata)
    );

    always #HALF_PERIOD clk = ~clk;

    task automatic check_value(input string name, input string what,
                               input logic [31:0] expected, input logic [31:0] actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("ERROR %s %s: expected 0x%08h, actual 0x%08h", name, what, expected, actual);
        end
    endtask

    task automatic check_idle(input string name);
        check_value(name, "stall", 32'd0, 32'(stall));
        check_value(name, "data_read", 32'd0, 32'(data_read));
        check_value(name, "data_write", 32'd0, 32'(data_write));
        check_value(name, "wb_valid", 32'd0, 32'(wb_valid));
        check_value(name, "data_mbe", 32'd0, 32'(data_mbe));
    endtask

    task automatic store_entry(input string name, input mem_path_pkg::store_funct3_t f3,
                               input logic [31:0] base, input logic [31:0] offset,
                               input logic [31:0] data, input logic [3:0] mbe);
        vec_t v;
        v            = '0;
        v.opcode     = mem_path_pkg::op_store;
        v.funct3     = f3;
        v.base       = base;
        v.offset     = offset;
        v.store_data = data;
        v.rd         = 5'd31;   // A live rd on a store must still never write back
        v.exp_mbe    = mbe;
        vecs.push_back(v);
        vec_names.push_back(name);
    endtask

    task automatic load_entry(input string name, input mem_path_pkg::load_funct3_t f3,
                              input logic [31:0] base, input logic [31:0] offset,
                              input logic [4:0] rd, input logic [31:0] expected);
        vec_t v;
        v          = '0;
        v.opcode   = mem_path_pkg::op_load;
        v.funct3   = f3;
        v.base     = base;
        v.offset   = offset;
        v.rd       = rd;
        v.exp_mbe  = 4'b1111;
        v.exp_data = expected;
        vecs.push_back(v);
        vec_names.push_back(name);
    endtask

    // Preloaded byte at address a is a ^ 0xC3, so word 0 reads C0C1C2C3
    task automatic build_table();
        store_entry("sw_word", mem_path_pkg::sw, 32'h40, 32'h10, 32'h1234_5678, 4'b1111);
        load_entry("lw_word", mem_path_pkg::lw, 32'h60, 32'hFFFF_FFF0, 5'd1, 32'h1234_5678);
        store_entry("sb_lane0", mem_path_pkg::sb, 32'h08, 32'h0, 32'hDEAD_BE11, 4'b0001);
        store_entry("sb_lane2", mem_path_pkg::sb, 32'h0, 32'h0A, 32'hDEAD_BE33, 4'b0100);
        load_entry("lw_after_sb02", mem_path_pkg::lw, 32'h08, 32'h0, 5'd2, 32'hC833_CA11);
        store_entry("sb_lane1", mem_path_pkg::sb, 32'h10, 32'hFFFF_FFF9, 32'h22, 4'b0010);
        store_entry("sb_lane3", mem_path_pkg::sb, 32'h0B, 32'h0, 32'hFFFF_FF44, 4'b1000);
        load_entry("lw_after_sb13", mem_path_pkg::lw, 32'h04, 32'h4, 5'd3, 32'h4433_2211);
        store_entry("sh_low", mem_path_pkg::sh, 32'h0C, 32'h0, 32'h55AA_BEEF, 4'b0011);
        load_entry("lw_after_sh0", mem_path_pkg::lw, 32'h0C, 32'h0, 5'd4, 32'hCCCD_BEEF);
        store_entry("sh_high", mem_path_pkg::sh, 32'h0D, 32'h1, 32'h1234_7007, 4'b1100);
        load_entry("lw_after_sh2", mem_path_pkg::lw, 32'h0C, 32'h0, 5'd5, 32'h7007_BEEF);
        load_entry("lb_off0", mem_path_pkg::lb, 32'h0, 32'h0, 5'd6, 32'hFFFF_FFC3);
        load_entry("lb_off1", mem_path_pkg::lb, 32'h0, 32'h1, 5'd7, 32'hFFFF_FFC2);
        load_entry("lb_off2", mem_path_pkg::lb, 32'h0, 32'h2, 5'd8, 32'hFFFF_FFC1);
        load_entry("lb_off3", mem_path_pkg::lb, 32'h0, 32'h3, 5'd9, 32'hFFFF_FFC0);
        load_entry("lbu_off0", mem_path_pkg::lbu, 32'h0, 32'h0, 5'd10, 32'h0000_00C3);
        load_entry("lbu_off1", mem_path_pkg::lbu, 32'h0, 32'h1, 5'd11, 32'h0000_00C2);
        load_entry("lbu_off2", mem_path_pkg::lbu, 32'h0, 32'h2, 5'd12, 32'h0000_00C1);
        load_entry("lbu_off3", mem_path_pkg::lbu, 32'h0, 32'h3, 5'd13, 32'h0000_00C0);
        load_entry("lh_off0", mem_path_pkg::lh, 32'h0, 32'h0, 5'd14, 32'hFFFF_C2C3);
        load_entry("lh_off2", mem_path_pkg::lh, 32'h0, 32'h2, 5'd15, 32'hFFFF_C0C1);
        load_entry("lhu_off0", mem_path_pkg::lhu, 32'h0, 32'h0, 5'd16, 32'h0000_C2C3);
        load_entry("lhu_off2", mem_path_pkg::lhu, 32'h0, 32'h2, 5'd17, 32'h0000_C0C1);
        load_entry("lh_pos", mem_path_pkg::lh, 32'h0E, 32'h0, 5'd18, 32'h0000_7007);
        load_entry("lb_stored", mem_path_pkg::lb, 32'h0D, 32'h0, 5'd19, 32'hFFFF_FFBE);
        load_entry("lbu_stored", mem_path_pkg::lbu, 32'h0F, 32'h0, 5'd20, 32'h0000_0070);
        load_entry("lb_pos", mem_path_pkg::lb, 32'h100, 32'hFFFF_FFFC, 5'd21, 32'h0000_003F);
        load_entry("lh_pos_hi", mem_path_pkg::lh, 32'hFE, 32'h0, 5'd22, 32'h0000_3C3D);
        load_entry("lw_word1", mem_path_pkg::lw, 32'h04, 32'h0, 5'd23, 32'hC4C5_C6C7);
        load_entry("lw_word4", mem_path_pkg::lw, 32'h10, 32'h0, 5'd24, 32'hD0D1_D2D3);
        load_entry("lw_word8", mem_path_pkg::lw, 32'h20, 32'h0, 5'd25, 32'hE0E1_E2E3);
    endtask

    initial begin
        clk      = 1'b0;
        rst      = 1'b1;
        op_valid = 1'b0;
        op_req   = '0;
        build_table();
        table_ready = 1'b1;
        repeat (2) begin
            @(negedge clk);
            check_idle("reset_active");
        end
        rst = 1'b0;
        @(negedge clk);
        check_idle("reset_release");

        // Requests go back to back and each one is held until accepted
        for (int i = 0; i < vecs.size(); i++) begin
            op_valid          = 1'b1;
            op_req.opcode     = vecs[i].opcode;
            op_req.funct3     = vecs[i].funct3;
            op_req.base       = vecs[i].base;
            op_req.offset     = vecs[i].offset;
            op_req.store_data = vecs[i].store_data;
            op_req.rd         = vecs[i].rd;
            port_q.push_back(i);
            if (vecs[i].opcode == mem_path_pkg::op_load) begin
                wb_q.push_back(i);
            end
            @(posedge clk);
            while (stall) begin
                @(posedge clk);
            end
            @(negedge clk);
        end
        op_valid = 1'b0;
        op_req   = '0;

        while (port_q.size() != 0 || wb_q.size() != 0) begin
            @(posedge clk);
        end
        // A few idle cycles catch any extra writeback pulse
        repeat (4) @(posedge clk);
        if (stall_cycles == 0) begin
            errors++;
            $display("Memory waits never raised stall");
        end
        $display("Summary: %0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

    // Memory port view of each completing access, in issue order
    always @(posedge clk) begin
        if (!rst && stall) begin
            stall_cycles++;
        end
        if (!rst && data_resp) begin
            if (port_q.size() == 0) begin
                errors++;
                $display("Memory access completed with no request outstanding");
            end else begin
                port_idx = port_q.pop_front();
                check_value(vec_names[port_idx], "data_write",
                            32'(vecs[port_idx].opcode == mem_path_pkg::op_store),
                            32'(data_write));
                check_value(vec_names[port_idx], "data_mbe",
                            32'(vecs[port_idx].exp_mbe), 32'(data_mbe));
                check_value(vec_names[port_idx], "data_addr",
                            (vecs[port_idx].base + vecs[port_idx].offset) & ~32'h3, data_addr);
            end
        end
    end

    always @(posedge clk) begin
        if (!rst && wb_valid) begin
            if (wb_q.size() == 0) begin
                errors++;
                $display("Writeback pulse to x%0d with no load outstanding", wb_rd);
            end else begin
                wb_idx = wb_q.pop_front();
                check_value(vec_names[wb_idx], "wb_rd", 32'(vecs[wb_idx].rd), 32'(wb_rd));
                check_value(vec_names[wb_idx], "wb_data", vecs[wb_idx].exp_data, wb_data);
            end
        end
    end

    // Worst case is a few stall cycles per access, so 8 periods each is ample
    initial begin
        wait (table_ready);
        repeat (vecs.size() * 8 + 20) @(posedge clk);
        $display("Timeout: the run did not finish within %0d clock periods",
                 vecs.size() * 8 + 20);
        $display("Summary: %0d checks, %0d errors", checks, errors);
        $display("*** TEST FAILED ***");
        $finish;
    end

endmodule

// File: verilog/load_writeback.sv
`timescale 1ns/1ps

module load_writeback (
    input  logic                                clk,
    input  logic                                rst,
    input  logic                                mem_done,
    input  mem_path_pkg::mem_access_t           mem_access,
    input  logic [mem_path_pkg::XLEN-1:0]       data_rdata,
    output logic                                wb_valid,
    output logic [mem_path_pkg::REG_ADDR_W-1:0] wb_rd,
    output logic [mem_path_pkg::XLEN-1:0]       wb_data
);

    logic                                load_done;
    logic [mem_path_pkg::REG_ADDR_W-1:0] rd_q;
    mem_path_pkg::load_funct3_t          funct3_q;
    logic [1:0]                          offset_q;
    logic [mem_path_pkg::XLEN-1:0]       rdata_q;
    logic [7:0]                          byte_sel;
    logic [15:0]                         half_sel;

    // Stores finish at the memory port and never reach writeback
    assign load_done = mem_done && (mem_access.opcode == mem_path_pkg::op_load);

    always_ff @(posedge clk) begin
        if (rst) begin
            wb_valid <= 1'b0;
        end else begin
            wb_valid <= load_done;
        end
    end

    always_ff @(posedge clk) begin
        if (load_done) begin
            rd_q     <= mem_access.rd;
            funct3_q <= mem_path_pkg::load_funct3_t'(mem_access.funct3);
            offset_q <= mem_access.addr[1:0];
            rdata_q  <= data_rdata;
        end
    end

    assign wb_rd = rd_q;

    // Lane select from the byte offset of the original address
    always_comb begin
        unique case (offset_q)
            2'b00: byte_sel = rdata_q[7:0];
            2'b01: byte_sel = rdata_q[15:8];
            2'b10: byte_sel = rdata_q[23:16];
            default: byte_sel = rdata_q[31:24];
        endcase
        half_sel = offset_q[1] ? rdata_q[31:16] : rdata_q[15:0];
    end

    always_comb begin
        unique case (funct3_q)
            mem_path_pkg::lb:  wb_data = {{24{byte_sel[7]}}, byte_sel};
            mem_path_pkg::lbu: wb_data = {24'd0, byte_sel};
            mem_path_pkg::lh:  wb_data = {{16{half_sel[15]}}, half_sel};
            mem_path_pkg::lhu: wb_data = {16'd0, half_sel};
            default:           wb_data = rdata_q;   // lw and anything unrecognized
        endcase
    end

endmodule

// File: verilog/mem_addr_stage.sv
`timescale 1ns/1ps

module mem_addr_stage (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      op_valid,
    input  mem_path_pkg::mem_req_t    op_req,
    input  logic                      stall,
    output logic                      ex_valid,
    output mem_path_pkg::mem_access_t ex_access
);

    mem_path_pkg::mem_req_t              req_q;
    logic [mem_path_pkg::XLEN-1:0]  addr;
    logic [mem_path_pkg::XLEN-1:0]  wdata;
    logic [mem_path_pkg::MBE_W-1:0] mbe;

    // The stage only advances when the request buffer can take its content
    always_ff @(posedge clk) begin
        if (rst) begin
            ex_valid <= 1'b0;
        end else if (!stall) begin
            ex_valid <= op_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall && op_valid) begin
            req_q <= op_req;
        end
    end

    assign addr = req_q.base + req_q.offset;

    // Place the store data in the lanes picked by the low address bits
    always_comb begin
        mbe   = 4'b1111;
        wdata = '0;
        if (req_q.opcode == mem_path_pkg::op_store) begin
            unique case (mem_path_pkg::store_funct3_t'(req_q.funct3))
                mem_path_pkg::sw: begin
                    wdata = req_q.store_data;
                    mbe   = 4'b1111;
                end
                mem_path_pkg::sh: begin
                    wdata = {16'd0, req_q.store_data[15:0]} << {addr[1], 4'b0000};
                    mbe   = 4'b0011 << {addr[1], 1'b0};
                end
                mem_path_pkg::sb: begin
                    wdata = {24'd0, req_q.store_data[7:0]} << {addr[1:0], 3'b000};
                    mbe   = 4'b0001 << addr[1:0];
                end
                default: begin
                    // Unknown width writes nothing
                    mbe = '0;
                end
            endcase
        end
    end

    always_comb begin
        ex_access.opcode = req_q.opcode;
        ex_access.funct3 = req_q.funct3;
        ex_access.addr   = addr;
        ex_access.wdata  = wdata;
        ex_access.mbe    = mbe;
        ex_access.rd     = req_q.rd;
    end

endmodule

// File: verilog/mem_path_top.sv
`timescale 1ns/1ps

module mem_path_top (
    input  logic                                clk,
    input  logic                                rst,
    input  logic                                op_valid,
    input  mem_path_pkg::mem_req_t              op_req,
    output logic                                stall,
    output logic                                data_read,
    output logic                                data_write,
    output logic [mem_path_pkg::MBE_W-1:0]      data_mbe,
    output logic [mem_path_pkg::XLEN-1:0]       data_addr,
    output logic [mem_path_pkg::XLEN-1:0]       data_wdata,
    input  logic                                data_resp,
    input  logic [mem_path_pkg::XLEN-1:0]       data_rdata,
    output logic                                wb_valid,
    output logic [mem_path_pkg::REG_ADDR_W-1:0] wb_rd,
    output logic [mem_path_pkg::XLEN-1:0]       wb_data
);

    logic                      ex_valid;
    mem_path_pkg::mem_access_t ex_access;
    logic                      mem_done;
    mem_path_pkg::mem_access_t mem_access;

    // Execute stage with address generation and store lane alignment
    mem_addr_stage i_mem_addr_stage (
        .clk       (clk),
        .rst       (rst),
        .op_valid  (op_valid),
        .op_req    (op_req),
        .stall     (stall),
        .ex_valid  (ex_valid),
        .ex_access (ex_access)
    );

    // EX/MEM register driving the data memory port
    mem_request_buffer i_mem_request_buffer (
        .clk        (clk),
        .rst        (rst),
        .ex_valid   (ex_valid),
        .ex_access  (ex_access),
        .stall      (stall),
        .data_read  (data_read),
        .data_write (data_write),
        .data_mbe   (data_mbe),
        .data_addr  (data_addr),
        .data_wdata (data_wdata),
        .data_resp  (data_resp),
        .mem_done   (mem_done),
        .mem_access (mem_access)
    );

    // MEM/WB register with load extraction
    load_writeback i_load_writeback (
        .clk        (clk),
        .rst        (rst),
        .mem_done   (mem_done),
        .mem_access (mem_access),
        .data_rdata (data_rdata),
        .wb_valid   (wb_valid),
        .wb_rd      (wb_rd),
        .wb_data    (wb_data)
    );

endmodule

// File: verilog/mem_request_buffer.sv
`timescale 1ns/1ps

module mem_request_buffer (
    input  logic                           clk,
    input  logic                           rst,
    input  logic                           ex_valid,
    input  mem_path_pkg::mem_access_t      ex_access,
    output logic                           stall,
    output logic                           data_read,
    output logic                           data_write,
    output logic [mem_path_pkg::MBE_W-1:0] data_mbe,
    output logic [mem_path_pkg::XLEN-1:0]  data_addr,
    output logic [mem_path_pkg::XLEN-1:0]  data_wdata,
    input  logic                           data_resp,
    output logic                           mem_done,
    output mem_path_pkg::mem_access_t      mem_access
);

    mem_path_pkg::mem_access_t held;
    logic                      held_valid;
    logic                      is_load;
    logic                      is_store;

    // The held access blocks everything behind it until memory answers
    assign stall    = held_valid && !data_resp;
    assign mem_done = held_valid && data_resp;

    // Refill when empty or when the held access completes at this edge
    always_ff @(posedge clk) begin
        if (rst) begin
            held_valid <= 1'b0;
        end else if (!stall) begin
            held_valid <= ex_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall && ex_valid) begin
            held <= ex_access;
        end
    end

    assign is_load  = held.opcode == mem_path_pkg::op_load;
    assign is_store = held.opcode == mem_path_pkg::op_store;

    // The port stays constant while the access waits
    assign data_read  = held_valid && is_load;
    assign data_write = held_valid && is_store;
    assign data_mbe   = (data_read || data_write) ? held.mbe : '0;
    assign data_addr  = {held.addr[mem_path_pkg::XLEN-1:2], 2'b00};
    assign data_wdata = held.wdata;

    // Writeback needs funct3, rd and the byte offset of the completing access
    assign mem_access = held;

endmodule
